// ==== logic/rhd_pkg.sv ====
package rhd_pkg;

    typedef logic [15:0] cmd_word_t;
    typedef logic [15:0] sample_t;
    typedef logic [5:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [4:0]  channel_t;
    typedef logic [5:0]  word_idx_t;
    typedef logic [1:0]  stream_t;    // line * 2 + half, a = 0, b = 1
    typedef logic [6:0]  word_cnt_t;  // clk cycle within one spi word
    typedef logic [1:0]  opcode_t;

    localparam int NUM_MISO    = 2;
    localparam int NUM_STREAMS = 2 * NUM_MISO;
    localparam int CHANNELS    = 32;

    localparam word_idx_t SEQ_WORDS       = 6'd40;
    localparam word_idx_t CONVERT_DELAY   = 6'd2;   // result returns two words after its convert
    localparam word_idx_t CONFIG_REGS     = 6'd22;
    localparam word_idx_t CAL_WORDS       = 6'd11;
    localparam word_idx_t RECORD_CONVERTS = word_idx_t'(CHANNELS);

    localparam reg_addr_t CHIP_ID_REG    = 6'd63;
    localparam logic      DSP_OFFSET_BIT = 1'b1;

    localparam word_cnt_t SCLK_QUARTER   = word_cnt_t'(1);
    localparam word_cnt_t HALF_BIT       = word_cnt_t'(2 * SCLK_QUARTER);
    localparam word_cnt_t BIT_CYCLES     = word_cnt_t'(4 * SCLK_QUARTER);
    localparam word_cnt_t CS_LOW_CYCLES  = word_cnt_t'($bits(cmd_word_t) * BIT_CYCLES);
    localparam word_cnt_t CS_HIGH_CYCLES = word_cnt_t'(4);
    localparam word_cnt_t WORD_CYCLES    = CS_LOW_CYCLES + CS_HIGH_CYCLES;  // 68

    localparam opcode_t CMD_CONVERT = 2'd0;
    localparam opcode_t CMD_WRITE   = 2'd2;
    localparam opcode_t CMD_READ    = 2'd3;

    localparam cmd_word_t CALIBRATE_WORD = 16'h5500;

    // register data for addresses 0 to 21
    // only the adc buffer bias (1) and mux bias (2) follow the rate
    localparam reg_data_t CONFIG_TABLE_LOW [CONFIG_REGS] = '{
        8'hde, 8'h20, 8'h28, 8'h00, 8'hc0, 8'h00, 8'h00, 8'h00,
        8'h16, 8'h00, 8'h17, 8'h00, 8'h23, 8'h11,
        8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff
    };

    localparam reg_data_t CONFIG_TABLE_HIGH [CONFIG_REGS] = '{
        8'hde, 8'h02, 8'h04, 8'h00, 8'hc0, 8'h00, 8'h00, 8'h00,
        8'h16, 8'h00, 8'h17, 8'h00, 8'h23, 8'h11,
        8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff
    };

    typedef struct packed {
        logic cs;
        logic sclk;
        logic mosi;
    } spi_out_t;

    typedef struct packed {
        sample_t [NUM_STREAMS-1:0] sample;  // indexed by stream_t
    } miso_words_t;

    typedef struct packed {
        logic        en;
        channel_t    channel;
        miso_words_t words;
    } frame_wr_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_TX,
        SEQ_RX,
        SEQ_FINISH
    } seq_state_t;

endpackage

// ==== logic/rhd_cmd_sequencer.sv ====
module rhd_cmd_sequencer (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 config_start,
    input  logic                 record_start,
    input  logic                 high_rate,
    output logic                 busy,
    output logic                 done,
    output logic                 start,
    output rhd_pkg::cmd_word_t   cmd,
    input  logic                 word_done,
    input  rhd_pkg::miso_words_t rx_words,
    output rhd_pkg::frame_wr_t   frame_wr
);

    rhd_pkg::seq_state_t state;
    logic                cfg_mode;   // high for a config run, low for a record run
    logic                rate_high;
    rhd_pkg::word_idx_t  word_idx;
    rhd_pkg::word_idx_t  rx_idx;
    rhd_pkg::cmd_word_t  next_cmd;
    rhd_pkg::reg_data_t  table_data;
    logic                capture;

    assign table_data = rate_high ? rhd_pkg::CONFIG_TABLE_HIGH[word_idx[4:0]]
                                  : rhd_pkg::CONFIG_TABLE_LOW[word_idx[4:0]];

    always_comb begin
        if (cfg_mode) begin
            if (word_idx < rhd_pkg::CONFIG_REGS) begin
                next_cmd = {rhd_pkg::CMD_WRITE, word_idx, table_data};  // index is the address
            end else if (word_idx < rhd_pkg::CONFIG_REGS + rhd_pkg::CAL_WORDS) begin
                next_cmd = rhd_pkg::CALIBRATE_WORD;
            end else begin
                next_cmd = {rhd_pkg::CMD_READ, rhd_pkg::CHIP_ID_REG, 8'h00};
            end
        end else begin
            if (word_idx < rhd_pkg::RECORD_CONVERTS) begin
                next_cmd = {rhd_pkg::CMD_CONVERT, word_idx, 7'd0, rhd_pkg::DSP_OFFSET_BIT};
            end else begin
                // dummy reads flush the last results
                next_cmd = {rhd_pkg::CMD_READ, rhd_pkg::CHIP_ID_REG, 8'h00};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= rhd_pkg::SEQ_IDLE;
            cfg_mode  <= 1'b0;
            rate_high <= 1'b0;
            word_idx  <= '0;
        end else begin
            case (state)
                rhd_pkg::SEQ_IDLE: begin
                    word_idx <= '0;
                    if (config_start || record_start) begin
                        cfg_mode  <= config_start;  // config wins
                        rate_high <= high_rate;
                        state     <= rhd_pkg::SEQ_LOAD;
                    end
                end
                rhd_pkg::SEQ_LOAD: begin
                    state <= rhd_pkg::SEQ_TX;
                end
                rhd_pkg::SEQ_TX: begin
                    state <= rhd_pkg::SEQ_RX;
                end
                rhd_pkg::SEQ_RX: begin
                    if (word_done) begin
                        if (word_idx == rhd_pkg::SEQ_WORDS - rhd_pkg::word_idx_t'(1)) begin
                            state <= rhd_pkg::SEQ_FINISH;
                        end else begin
                            word_idx <= word_idx + rhd_pkg::word_idx_t'(1);
                            state    <= rhd_pkg::SEQ_LOAD;
                        end
                    end
                end
                rhd_pkg::SEQ_FINISH: begin
                    state <= rhd_pkg::SEQ_IDLE;
                end
                default: begin
                    state <= rhd_pkg::SEQ_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rhd_pkg::SEQ_LOAD) begin
            cmd <= next_cmd;
        end
    end

    assign busy  = (state != rhd_pkg::SEQ_IDLE);
    assign done  = (state == rhd_pkg::SEQ_FINISH);
    assign start = (state == rhd_pkg::SEQ_TX);

    // the word finishing now carries the result of the convert sent two words earlier
    assign rx_idx  = word_idx - rhd_pkg::CONVERT_DELAY;
    assign capture = (state == rhd_pkg::SEQ_RX) && word_done && !cfg_mode
                     && (word_idx >= rhd_pkg::CONVERT_DELAY)
                     && (word_idx < rhd_pkg::RECORD_CONVERTS + rhd_pkg::CONVERT_DELAY);

    assign frame_wr.en      = capture;
    assign frame_wr.channel = rhd_pkg::channel_t'(rx_idx);
    assign frame_wr.words   = rx_words;

endmodule

// ==== logic/rhd_spi_engine.sv ====
module rhd_spi_engine (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         start,
    input  rhd_pkg::cmd_word_t           cmd,
    input  logic [rhd_pkg::NUM_MISO-1:0] miso,
    output rhd_pkg::spi_out_t            spi,
    output logic                         done,
    output rhd_pkg::miso_words_t         rx_words
);

    logic                active;
    rhd_pkg::word_cnt_t  cnt;         // cycle of the word, 0 is the first cs low cycle
    rhd_pkg::word_cnt_t  cnt_next;
    rhd_pkg::word_cnt_t  phase_next;  // cycle within the bit being entered
    rhd_pkg::cmd_word_t  tx_word;
    rhd_pkg::sample_t    a_sr [rhd_pkg::NUM_MISO];
    rhd_pkg::sample_t    b_sr [rhd_pkg::NUM_MISO];
    logic                launch;
    logic                in_frame;
    logic                bit_edge;
    logic                sclk_rise;
    logic                sclk_fall;
    logic                last_cycle;

    assign launch     = start && !active;
    assign cnt_next   = cnt + rhd_pkg::word_cnt_t'(1);
    assign phase_next = cnt_next % rhd_pkg::BIT_CYCLES;
    assign in_frame   = cnt_next < rhd_pkg::CS_LOW_CYCLES;
    assign bit_edge   = active && in_frame && (phase_next == '0);
    assign sclk_rise  = active && in_frame && (phase_next == rhd_pkg::HALF_BIT);
    // the last falling edge coincides with cs going high
    assign sclk_fall  = active && (phase_next == '0) && (cnt_next <= rhd_pkg::CS_LOW_CYCLES);
    assign last_cycle = active && (cnt_next == rhd_pkg::WORD_CYCLES - rhd_pkg::word_cnt_t'(1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            active <= 1'b0;
            cnt    <= '0;
            spi    <= '{cs: 1'b1, sclk: 1'b0, mosi: 1'b0};
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (launch) begin
                active   <= 1'b1;
                cnt      <= '0;
                spi.cs   <= 1'b0;
                spi.sclk <= 1'b0;
                spi.mosi <= cmd[15];  // msb first
            end else if (active) begin
                cnt      <= cnt_next;
                spi.cs   <= !in_frame;
                spi.sclk <= in_frame && (phase_next >= rhd_pkg::HALF_BIT);
                if (!in_frame) begin
                    spi.mosi <= 1'b0;
                end else if (bit_edge) begin
                    spi.mosi <= tx_word[14];
                end
                if (last_cycle) begin
                    active <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            tx_word <= cmd;
        end else if (bit_edge) begin
            tx_word <= tx_word << 1;
        end
        for (int l = 0; l < rhd_pkg::NUM_MISO; l++) begin
            if (sclk_rise) begin
                a_sr[l] <= {a_sr[l][14:0], miso[l]};  // chip drives a while sclk is low
            end
            if (sclk_fall) begin
                b_sr[l] <= {b_sr[l][14:0], miso[l]};
            end
        end
        if (last_cycle) begin
            for (int l = 0; l < rhd_pkg::NUM_MISO; l++) begin
                rx_words.sample[2*l]   <= a_sr[l];
                rx_words.sample[2*l+1] <= b_sr[l];
            end
        end
    end

endmodule

// ==== logic/rhd_frame_buffer.sv ====
module rhd_frame_buffer (
    input  logic                clk,
    input  logic                rstn,
    input  rhd_pkg::frame_wr_t  wr,
    input  rhd_pkg::stream_t    rd_stream,
    input  rhd_pkg::channel_t   rd_channel,
    output rhd_pkg::sample_t    rd_sample
);

    // one row per channel, each row holds the samples of every stream
    rhd_pkg::miso_words_t mem [rhd_pkg::CHANNELS];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.channel] <= wr.words;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_sample <= '0;
        end else begin
            rd_sample <= mem[rd_channel].sample[rd_stream];  // one cycle read latency
        end
    end

endmodule

// ==== logic/rhd_acq_top.sv ====
module rhd_acq_top (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         config_start,
    input  logic                         record_start,
    input  logic                         high_rate,
    input  logic [rhd_pkg::NUM_MISO-1:0] miso,
    output rhd_pkg::spi_out_t            spi,
    output logic                         busy,
    output logic                         done,
    input  rhd_pkg::stream_t             rd_stream,
    input  rhd_pkg::channel_t            rd_channel,
    output rhd_pkg::sample_t             rd_sample
);

    logic                 word_start;
    logic                 word_done;
    rhd_pkg::cmd_word_t   cmd;
    rhd_pkg::miso_words_t rx_words;
    rhd_pkg::frame_wr_t   frame_wr;

    rhd_cmd_sequencer i_rhd_cmd_sequencer (
        .clk          (clk),
        .rstn         (rstn),
        .config_start (config_start),
        .record_start (record_start),
        .high_rate    (high_rate),
        .busy         (busy),
        .done         (done),
        .start        (word_start),
        .cmd          (cmd),
        .word_done    (word_done),
        .rx_words     (rx_words),
        .frame_wr     (frame_wr)
    );

    rhd_spi_engine i_rhd_spi_engine (
        .clk      (clk),
        .rstn     (rstn),
        .start    (word_start),
        .cmd      (cmd),
        .miso     (miso),
        .spi      (spi),
        .done     (word_done),
        .rx_words (rx_words)
    );

    rhd_frame_buffer i_rhd_frame_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .wr         (frame_wr),
        .rd_stream  (rd_stream),
        .rd_channel (rd_channel),
        .rd_sample  (rd_sample)
    );

endmodule

// ==== verification/rhd_chip_model.sv ====
module rhd_chip_model (
    input  logic                         cs,
    input  logic                         sclk,
    input  logic                         mosi,
    output logic [rhd_pkg::NUM_MISO-1:0] miso,
    output rhd_pkg::cmd_word_t           last_word,
    output int                           word_count,
    output int                           last_rises,
    output rhd_pkg::reg_data_t [0:21]    table_low,
    output rhd_pkg::reg_data_t [0:21]    table_high
);

    timeunit 1ns;
    timeprecision 1ps;

    // register data the chip expects for addresses 0 to 21
    localparam rhd_pkg::reg_data_t [0:21] REG_LOW = {
        8'hde, 8'h20, 8'h28, 8'h00, 8'hc0, 8'h00, 8'h00, 8'h00,
        8'h16, 8'h00, 8'h17, 8'h00, 8'h23, 8'h11,
        8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff
    };

    localparam rhd_pkg::reg_data_t [0:21] REG_HIGH = {
        8'hde, 8'h02, 8'h04, 8'h00, 8'hc0, 8'h00, 8'h00, 8'h00,
        8'h16, 8'h00, 8'h17, 8'h00, 8'h23, 8'h11,
        8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff
    };

    rhd_pkg::cmd_word_t shift_in = '0;
    rhd_pkg::cmd_word_t word_out = '0;
    rhd_pkg::cmd_word_t hist [2] = '{16'hffff, 16'hffff};  // reads, no convert pending
    rhd_pkg::sample_t   tx_a [rhd_pkg::NUM_MISO] = '{default: '0};
    rhd_pkg::sample_t   tx_b [rhd_pkg::NUM_MISO] = '{default: '0};
    logic               prev_cs = 1'b0;
    logic               prev_sclk = 1'b0;
    logic               in_word = 1'b0;
    int                 rises = 0;
    int                 n_rises = 0;
    int                 n_words = 0;

    assign table_low  = REG_LOW;
    assign table_high = REG_HIGH;
    assign last_word  = word_out;
    assign word_count = n_words;
    assign last_rises = n_rises;

    always_comb begin
        for (int l = 0; l < rhd_pkg::NUM_MISO; l++) begin
            miso[l] = sclk ? tx_b[l][15] : tx_a[l][15];  // a while low, b while high
        end
    end

    always @(cs or sclk) begin
        if (prev_cs && !cs) begin
            in_word = 1'b1;
            rises   = 0;
            // answer the convert sent two words back
            for (int l = 0; l < rhd_pkg::NUM_MISO; l++) begin
                if (hist[1][15:14] == 2'b00) begin
                    tx_a[l] = rhd_pkg::sample_t'(l * 4096 + int'(hist[1][13:8]));
                    tx_b[l] = rhd_pkg::sample_t'(l * 4096 + 2048 + int'(hist[1][13:8]));
                end else begin
                    tx_a[l] = '0;
                    tx_b[l] = '0;
                end
            end
        end
        if (!prev_sclk && sclk && !cs) begin
            shift_in = {shift_in[14:0], mosi};
            rises    = rises + 1;
            for (int l = 0; l < rhd_pkg::NUM_MISO; l++) begin
                tx_a[l] = tx_a[l] << 1;
            end
        end
        if (prev_sclk && !sclk) begin
            for (int l = 0; l < rhd_pkg::NUM_MISO; l++) begin
                tx_b[l] = tx_b[l] << 1;
            end
        end
        if (!prev_cs && cs && in_word) begin
            in_word  = 1'b0;
            word_out = shift_in;
            n_rises  = rises;
            n_words  = n_words + 1;
            hist[1]  = hist[0];
            hist[0]  = shift_in;
        end
        prev_cs   = cs;
        prev_sclk = sclk;
    end

endmodule

// ==== verification/rhd_acq_tb.sv ====
module rhd_acq_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RUN_CYCLES = int'(rhd_pkg::SEQ_WORDS) * (int'(rhd_pkg::WORD_CYCLES) + 2) + 1;
    localparam int NUM_RUNS = 4;
    localparam int MAX_GAP = 35;
    localparam int READ_CYCLES = rhd_pkg::NUM_STREAMS * rhd_pkg::CHANNELS + 2;
    localparam int TIMEOUT_CYCLES = 16 + 30 + NUM_RUNS * (RUN_CYCLES + MAX_GAP + 4)
                                    + 2 * READ_CYCLES + 100;

    logic                         clk;
    logic                         rstn;
    logic                         config_start;
    logic                         record_start;
    logic                         high_rate;
    logic [rhd_pkg::NUM_MISO-1:0] miso;
    rhd_pkg::spi_out_t            spi;
    logic                         busy;
    logic                         done;
    rhd_pkg::stream_t             rd_stream;
    rhd_pkg::channel_t            rd_channel;
    rhd_pkg::sample_t             rd_sample;
    rhd_pkg::cmd_word_t           last_word;
    int                           word_count;
    int                           last_rises;
    rhd_pkg::reg_data_t [0:21]    table_low;
    rhd_pkg::reg_data_t [0:21]    table_high;

    logic [31:0] lfsr = 32'h22508473;
    int          cycle_count = 0;
    int          words_seen = 0;
    int          run_base = 0;
    int          cs_high_run = 0;
    logic        run_active = 1'b0;
    logic        exp_cfg = 1'b0;
    logic        exp_rate = 1'b0;

    rhd_acq_top i_rhd_acq_top (
        .clk          (clk),
        .rstn         (rstn),
        .config_start (config_start),
        .record_start (record_start),
        .high_rate    (high_rate),
        .miso         (miso),
        .spi          (spi),
        .busy         (busy),
        .done         (done),
        .rd_stream    (rd_stream),
        .rd_channel   (rd_channel),
        .rd_sample    (rd_sample)
    );

    rhd_chip_model i_rhd_chip_model (
        .cs         (spi.cs),
        .sclk       (spi.sclk),
        .mosi       (spi.mosi),
        .miso       (miso),
        .last_word  (last_word),
        .word_count (word_count),
        .last_rises (last_rises),
        .table_low  (table_low),
        .table_high (table_high)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic value_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic stop_with(input string why);
        $display("Error at %0d ns: %s", $time, why);
        abort_run();
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // expected command word k of a config run or a record run
    function automatic rhd_pkg::cmd_word_t expect_word(input logic cfg, input logic rate,
                                                       input int k);
        rhd_pkg::reg_data_t data;
        if (cfg && k < 22) begin
            data = rate ? table_high[k[4:0]] : table_low[k[4:0]];
            return {2'b10, k[5:0], data};
        end
        if (cfg && k < 33) begin
            return 16'h5500;
        end
        if (!cfg && k < 32) begin
            return {2'b00, k[5:0], 7'd0, 1'b1};  // dsp offset bit set
        end
        return {2'b11, 6'd63, 8'h00};
    endfunction

    function automatic rhd_pkg::sample_t expect_sample(input int s, input int c);
        return rhd_pkg::sample_t'((s / 2) * 4096 + (s % 2) * 2048 + c);
    endfunction

    task automatic idle_for(input int n);
        repeat (n) begin
            @(negedge clk);
            assert (!busy && !done && spi.cs && !spi.sclk && !spi.mosi)
                else stop_with("interface not idle while no run is started");
        end
    endtask

    task automatic idle_gap();
        logic [7:0] bits;
        take_bits(5, bits);
        idle_for(4 + int'(bits[4:0]));
    endtask

    task automatic run_sequence(input logic do_config, input logic do_record, input logic rate,
                                input logic intrude);
        int cycles;
        @(negedge clk);
        exp_cfg      = do_config;  // config wins when both are raised
        exp_rate     = rate;
        run_base     = words_seen;
        run_active   = 1'b1;
        config_start = do_config;
        record_start = do_record;
        high_rate    = rate;
        @(negedge clk);
        config_start = 1'b0;
        record_start = 1'b0;
        high_rate    = ~rate;  // rate must stay latched from the accepting edge
        cycles       = 1;
        assert (busy) else value_fail("busy", 32'(busy), 32'd1);
        while (!done) begin
            if (intrude && cycles == 300) begin
                config_start = !do_config;
                record_start = do_config;
            end
            if (cycles == 303) begin
                config_start = 1'b0;
                record_start = 1'b0;
            end
            @(negedge clk);
            cycles++;
            assert (busy) else value_fail("busy", 32'(busy), 32'd1);
            assert (cycles <= RUN_CYCLES)
                else stop_with("done did not pulse at the end of the run");
        end
        assert (cycles == RUN_CYCLES) else value_fail("run cycles", cycles, RUN_CYCLES);
        assert (words_seen - run_base == 40)
            else value_fail("words in run", words_seen - run_base, 32'd40);
        @(negedge clk);
        assert (!busy && !done) else stop_with("busy or done still high after the done pulse");
        run_active = 1'b0;
    endtask

    // one address per cycle with each result checked one cycle later
    task automatic read_frame();
        rhd_pkg::sample_t exp_sample;
        for (int i = 0; i <= rhd_pkg::NUM_STREAMS * rhd_pkg::CHANNELS; i++) begin
            @(negedge clk);
            if (i > 0) begin
                exp_sample = expect_sample((i - 1) / rhd_pkg::CHANNELS,
                                           (i - 1) % rhd_pkg::CHANNELS);
                assert (rd_sample == exp_sample)
                    else value_fail("rd_sample", 32'(rd_sample), 32'(exp_sample));
            end
            if (i < rhd_pkg::NUM_STREAMS * rhd_pkg::CHANNELS) begin
                rd_stream  = rhd_pkg::stream_t'(i / rhd_pkg::CHANNELS);
                rd_channel = rhd_pkg::channel_t'(i % rhd_pkg::CHANNELS);
            end
        end
    endtask

    always @(negedge clk) begin : check_words
        rhd_pkg::cmd_word_t exp_cmd;
        int                 k;
        if (rstn) begin
            if (spi.cs) begin
                cs_high_run++;
            end else begin
                if (cs_high_run > 0) begin
                    assert (cs_high_run >= int'(rhd_pkg::CS_HIGH_CYCLES))
                        else value_fail("cs high cycles", cs_high_run, 32'(rhd_pkg::CS_HIGH_CYCLES));
                end
                cs_high_run = 0;
            end
            if (word_count != words_seen) begin
                words_seen = word_count;
                k          = words_seen - run_base - 1;
                assert (run_active) else stop_with("a command word went out with no run started");
                assert (k < 40) else stop_with("more than 40 words in one run");
                assert (last_rises == 16) else value_fail("sclk rises", last_rises, 32'd16);
                exp_cmd = expect_word(exp_cfg, exp_rate, k);
                assert (last_word == exp_cmd)
                    else value_fail("mosi word", 32'(last_word), 32'(exp_cmd));
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) spi.cs |-> !spi.sclk)
        else stop_with("SCLK was high while CS was high");

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_with("timeout, the tests did not finish in time");
        end
    end

    initial begin
        logic [7:0] bits;
        logic       first_rate;
        rstn         = 1'b0;
        config_start = 1'b0;
        record_start = 1'b0;
        high_rate    = 1'b0;
        rd_stream    = '0;
        rd_channel   = '0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        idle_for(20);
        take_bits(1, bits);
        first_rate = bits[0];
        run_sequence(1'b1, 1'b0, first_rate, 1'b0);
        idle_gap();
        take_bits(1, bits);
        run_sequence(1'b0, 1'b1, bits[0], 1'b1);  // config start during record is ignored
        read_frame();
        idle_gap();
        run_sequence(1'b1, 1'b1, !first_rate, 1'b1);
        idle_gap();
        take_bits(1, bits);
        run_sequence(1'b0, 1'b1, bits[0], 1'b0);
        read_frame();
        idle_for(10);
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== rhd_acq.f ====
logic/rhd_pkg.sv
logic/rhd_cmd_sequencer.sv
logic/rhd_spi_engine.sv
logic/rhd_frame_buffer.sv
logic/rhd_acq_top.sv
verification/rhd_chip_model.sv
verification/rhd_acq_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FILELIST  = rhd_acq.f
TOP       = rhd_acq_tb
FLAGS     = --timing --assert --timescale 1ns/1ps
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
